// File: rtl/iir_params.svh
// Biquad section build constants
// Sample and coefficient width, tap count, result slice position
// and depth of the stream FIFOs

`ifndef IIR_PARAMS_SVH
`define IIR_PARAMS_SVH

// Sample and coefficient width in bits
`define IIR_DATA_W      18

// Fixed biquad program, three feedforward and two feedback taps
`define IIR_NUM_COEFS   5

// Low bit of the result slice taken from the accumulator
`define IIR_FRAC_SHIFT  16

// Entries per stream FIFO
`define IIR_FIFO_DEPTH  4

`endif

// File: rtl/iir_pkg.sv
// Biquad filter types
// Samples, coefficients, accumulator, MAC opmodes and the result
// record handed to the output stream

`include "iir_params.svh"

package iir_pkg;

    // Signed fixed-point sample
    typedef logic signed [`IIR_DATA_W-1:0] sample_t;

    // Signed coefficient, feedback terms stored negated
    typedef logic signed [`IIR_DATA_W-1:0] coef_t;

    // Coefficient and delay-line index
    typedef logic [$clog2(`IIR_NUM_COEFS)-1:0] coef_addr_t;

    // Full-width accumulator of the MAC slice
    typedef logic signed [47:0] acc_t;

    // MAC operation per cycle
    typedef enum logic [1:0] {
        NOP       = 2'd0,
        MULT_ZERO = 2'd1,
        MULT_ACC  = 2'd2
    } dsp_opmode_t;

    // Output sample with its overflow flag
    typedef struct packed {
        sample_t data;
        logic    ovf;
    } iir_result_t;

endpackage

// File: rtl/dsp_if.sv
// Sequencer to MAC link
// Operands and opmode go to the MAC slice, the accumulator
// comes back. No handshake, the MAC acts every cycle.

`timescale 1ns/1ps

interface dsp_if;
    import iir_pkg::*;

    dsp_opmode_t opmode;
    // Coefficient operand
    coef_t       a;
    // Sample operand
    sample_t     b;
    // Registered accumulator
    acc_t        p;

    modport seq (
        output opmode,
        output a,
        output b,
        input  p
    );

    modport mac (
        input  opmode,
        input  a,
        input  b,
        output p
    );

endinterface

// File: rtl/dsp_mac.sv
// Multiply-accumulate slice in the manner of a DSP48 block
// Forms the signed product of a and b and adds it to zero or to
// the previous accumulator value. One cycle of latency.

`timescale 1ns/1ps

`include "iir_params.svh"

module dsp_mac (
    input logic clk,
    input logic reset,
    dsp_if.mac  dsp
);
    import iir_pkg::*;

    logic signed [2*`IIR_DATA_W-1:0] mult;
    acc_t                            product;
    acc_t                            p_q;

    // ------------------------------------------------------------
    // Multiplier
    // ------------------------------------------------------------
    assign mult    = dsp.a * dsp.b;
    // Sign extend to accumulator width
    assign product = acc_t'(mult);

    // ------------------------------------------------------------
    // Accumulator with Z mux
    // ------------------------------------------------------------
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            p_q <= '0;
        end else begin
            case (dsp.opmode)
                // Z = 0
                MULT_ZERO: p_q <= product;
                // Z = P, wraps at 48 bits
                MULT_ACC:  p_q <= p_q + product;
                default:   p_q <= p_q;
            endcase
        end
    end

    assign dsp.p = p_q;

    // Sequencer must only issue defined operations
    a_opmode_legal: assert property (
        @(posedge clk) disable iff (reset)
        dsp.opmode inside {NOP, MULT_ZERO, MULT_ACC}
    ) else $error("dsp_mac: illegal opmode %0d", dsp.opmode);

endmodule

// File: rtl/stream_fifo.sv
// Valid/ready stream FIFO
// Circular buffer with read and write pointers and an occupancy
// count. A push shows at the output one cycle later.

`timescale 1ns/1ps

`include "iir_params.svh"

module stream_fifo #(
    parameter type T     = logic,
    parameter int  DEPTH = `IIR_FIFO_DEPTH
) (
    input  logic clk,
    input  logic reset,
    input  logic push_valid,
    output logic push_ready,
    input  T     push_data,
    output logic pop_valid,
    input  logic pop_ready,
    output T     pop_data
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    T                 mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             do_push;
    logic             do_pop;

    // Pointer advance with wrap for any depth
    function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign push_ready = (count != CNT_W'(DEPTH));
    assign pop_valid  = (count != '0);
    assign do_push    = push_valid && push_ready;
    assign do_pop     = pop_valid && pop_ready;
    assign pop_data   = mem[rd_ptr];

    // Storage
    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    // Pointers and occupancy
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= ptr_next(wr_ptr);
            end
            if (do_pop) begin
                rd_ptr <= ptr_next(rd_ptr);
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    a_count_bound: assert property (
        @(posedge clk) disable iff (reset)
        count <= CNT_W'(DEPTH)
    ) else $error("stream_fifo: count %0d above depth", count);

    // Head entry must hold while the consumer stalls
    a_pop_stable: assert property (
        @(posedge clk) disable iff (reset)
        pop_valid && !pop_ready |=> $stable(pop_data)
    ) else $error("stream_fifo: pop_data changed while stalled");

endmodule

// File: rtl/coef_bank.sv
// Coefficient register file for the biquad program
// Five entries written over a valid/ready port that only accepts
// while the sequencer is idle

`timescale 1ns/1ps

`include "iir_params.svh"

module coef_bank (
    input  logic                clk,
    input  logic                reset,
    input  logic                idle,
    input  logic                wr_valid,
    output logic                wr_ready,
    input  iir_pkg::coef_addr_t wr_addr,
    input  iir_pkg::coef_t      wr_data,
    output iir_pkg::coef_t      coefs [`IIR_NUM_COEFS]
);
    import iir_pkg::*;

    logic wr_en;

    // Coefficients stay frozen during a computation
    assign wr_ready = idle;
    assign wr_en    = wr_valid && wr_ready;

    // ------------------------------------------------------------
    // Address decode and storage
    // ------------------------------------------------------------
    // Addresses past the last tap match no entry and are dropped
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < `IIR_NUM_COEFS; i++) begin
                coefs[i] <= '0;
            end
        end else if (wr_en) begin
            for (int i = 0; i < `IIR_NUM_COEFS; i++) begin
                if (wr_addr == coef_addr_t'(i)) begin
                    coefs[i] <= wr_data;
                end
            end
        end
    end

endmodule

// File: rtl/iir_sequencer.sv
// Microcoded biquad sequencer
// A small program ROM walks five MACs through the shared DSP slice,
// keeps the x/y delay line and hands each result to the output
// stream. Result ready nine cycles after a sample is accepted.

`timescale 1ns/1ps

`include "iir_params.svh"

module iir_sequencer (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 s_valid,
    output logic                 s_ready,
    input  iir_pkg::sample_t     s_data,
    output logic                 r_valid,
    input  logic                 r_ready,
    output iir_pkg::iir_result_t r_data,
    input  iir_pkg::coef_t       coefs [`IIR_NUM_COEFS],
    output logic                 idle,
    dsp_if.seq                   dsp
);
    import iir_pkg::*;

    localparam int SLICE_HI = `IIR_FRAC_SHIFT + `IIR_DATA_W - 1;
    localparam int ACC_MSB  = $bits(acc_t) - 1;

    // Program addresses
    localparam logic [2:0] PC_WAIT  = 3'd0;
    localparam logic [2:0] PC_LOAD  = 3'd1;
    localparam logic [2:0] PC_MACS  = 3'd2;
    localparam logic [2:0] PC_LAST  = 3'd3;
    localparam logic [2:0] PC_DRAIN = 3'd4;
    localparam logic [2:0] PC_STORE = 3'd5;

    // Task flags issued per program step
    localparam logic [8:0] T_WAIT     = 9'h001;
    localparam logic [8:0] T_PUSH_X   = 9'h002;
    localparam logic [8:0] T_MAC_ZERO = 9'h004;
    localparam logic [8:0] T_MAC_ACC  = 9'h008;
    localparam logic [8:0] T_IDX_CLR  = 9'h010;
    localparam logic [8:0] T_IDX_INC  = 9'h020;
    localparam logic [8:0] T_REPEAT_3 = 9'h040;
    localparam logic [8:0] T_CAPTURE  = 9'h080;
    localparam logic [8:0] T_JUMP_0   = 9'h100;

    localparam logic [1:0] REP_LAST = 2'd2;

    logic [2:0]  pc;
    logic [8:0]  tasks;
    logic [1:0]  rep_cnt;
    logic        rep_done;
    coef_addr_t  idx;
    sample_t     x_in;
    sample_t     xy [`IIR_NUM_COEFS];
    logic        accept;
    logic        mac_zero;
    logic        mac_acc;
    dsp_opmode_t opmode_q;
    coef_t       a_q;
    sample_t     b_q;
    sample_t     y_slice;
    logic        y_ovf;

    // ------------------------------------------------------------
    // Program ROM
    // ------------------------------------------------------------
    always_comb begin
        case (pc)
            PC_WAIT:  tasks = T_WAIT;
            PC_LOAD:  tasks = T_PUSH_X | T_MAC_ZERO | T_IDX_INC;
            PC_MACS:  tasks = T_REPEAT_3 | T_MAC_ACC | T_IDX_INC;
            PC_LAST:  tasks = T_MAC_ACC | T_IDX_CLR;
            // Let the last product settle in the accumulator
            PC_DRAIN: tasks = T_REPEAT_3;
            PC_STORE: tasks = T_CAPTURE | T_JUMP_0;
            default:  tasks = T_JUMP_0;
        endcase
    end

    assign idle     = |(tasks & T_WAIT);
    assign s_ready  = idle && !r_valid;
    assign accept   = s_valid && s_ready;
    assign mac_zero = |(tasks & T_MAC_ZERO);
    assign mac_acc  = |(tasks & T_MAC_ACC);
    assign rep_done = !(|(tasks & T_REPEAT_3)) || (rep_cnt == REP_LAST);

    // Program counter
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pc <= PC_WAIT;
        end else if (|(tasks & T_JUMP_0)) begin
            pc <= PC_WAIT;
        end else if ((idle && !accept) || !rep_done) begin
            pc <= pc;
        end else begin
            pc <= pc + 3'd1;
        end
    end

    // Repeat counter for three passes per repeated step
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            rep_cnt <= '0;
        end else if (|(tasks & T_REPEAT_3)) begin
            rep_cnt <= rep_done ? 2'd0 : rep_cnt + 2'd1;
        end
    end

    // Index register
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            idx <= '0;
        end else if (|(tasks & T_IDX_CLR)) begin
            idx <= '0;
        end else if (|(tasks & T_IDX_INC)) begin
            idx <= idx + 1'b1;
        end
    end

    // ------------------------------------------------------------
    // Sample capture and x/y delay line
    // ------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (accept) begin
            x_in <= s_data;
        end
    end

    // Entries 0..2 hold x[n..n-2], entries 3..4 hold y[n-1..n-2]
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < `IIR_NUM_COEFS; i++) begin
                xy[i] <= '0;
            end
        end else if (|(tasks & T_PUSH_X)) begin
            xy[0] <= x_in;
            xy[1] <= xy[0];
            xy[2] <= xy[1];
        end else if (|(tasks & T_CAPTURE)) begin
            xy[3] <= y_slice;
            xy[4] <= xy[3];
        end
    end

    // ------------------------------------------------------------
    // MAC issue
    // ------------------------------------------------------------
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            opmode_q <= NOP;
        end else if (mac_zero) begin
            opmode_q <= MULT_ZERO;
        end else if (mac_acc) begin
            opmode_q <= MULT_ACC;
        end else begin
            opmode_q <= NOP;
        end
    end

    // First tap takes the new sample before it reaches the line
    always_ff @(posedge clk) begin
        if (mac_zero) begin
            a_q <= coefs[idx];
            b_q <= x_in;
        end else if (mac_acc) begin
            a_q <= coefs[idx];
            b_q <= xy[idx];
        end
    end

    assign dsp.opmode = opmode_q;
    assign dsp.a      = a_q;
    assign dsp.b      = b_q;

    // ------------------------------------------------------------
    // Result slice and output hold
    // ------------------------------------------------------------
    assign y_slice = dsp.p[SLICE_HI:`IIR_FRAC_SHIFT];
    // Upper bits must all match the slice sign
    assign y_ovf   = !((&dsp.p[ACC_MSB:SLICE_HI]) || !(|dsp.p[ACC_MSB:SLICE_HI]));

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            r_valid <= 1'b0;
        end else if (|(tasks & T_CAPTURE)) begin
            r_valid <= 1'b1;
        end else if (r_ready) begin
            r_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (|(tasks & T_CAPTURE)) begin
            r_data.data <= y_slice;
            r_data.ovf  <= y_ovf;
        end
    end

    a_idx_range: assert property (
        @(posedge clk) disable iff (reset)
        (mac_zero || mac_acc) |-> (idx < coef_addr_t'(`IIR_NUM_COEFS))
    ) else $error("iir_sequencer: MAC issued with index %0d", idx);

    // A stalled result keeps its value and blocks new samples
    a_result_hold: assert property (
        @(posedge clk) disable iff (reset)
        (r_valid && !r_ready) |=> (r_valid && $stable(r_data) && !s_ready)
    ) else $error("iir_sequencer: pending result changed or input accepted");

endmodule

// File: rtl/iir_filter_top.sv
// Biquad IIR filter section
// Input FIFO, microcoded sequencer, shared MAC slice, coefficient
// bank and output FIFO joined behind plain stream ports

`timescale 1ns/1ps

`include "iir_params.svh"

module iir_filter_top (
    input  logic                clk,
    input  logic                reset,
    input  logic                in_valid,
    output logic                in_ready,
    input  iir_pkg::sample_t    in_data,
    output logic                out_valid,
    input  logic                out_ready,
    output iir_pkg::sample_t    out_data,
    output logic                out_ovf,
    input  logic                coef_valid,
    output logic                coef_ready,
    input  iir_pkg::coef_addr_t coef_addr,
    input  iir_pkg::coef_t      coef_data
);
    import iir_pkg::*;

    logic        s_valid;
    logic        s_ready;
    sample_t     s_data;
    logic        r_valid;
    logic        r_ready;
    iir_result_t r_data;
    iir_result_t out_res;
    coef_t       coefs [`IIR_NUM_COEFS];
    logic        idle;

    dsp_if dsp0 ();

    // Input samples
    stream_fifo #(.T(sample_t)) u_in_fifo (
        .clk        (clk),
        .reset      (reset),
        .push_valid (in_valid),
        .push_ready (in_ready),
        .push_data  (in_data),
        .pop_valid  (s_valid),
        .pop_ready  (s_ready),
        .pop_data   (s_data)
    );

    coef_bank u_coef_bank (
        .clk      (clk),
        .reset    (reset),
        .idle     (idle),
        .wr_valid (coef_valid),
        .wr_ready (coef_ready),
        .wr_addr  (coef_addr),
        .wr_data  (coef_data),
        .coefs    (coefs)
    );

    iir_sequencer u_seq (
        .clk     (clk),
        .reset   (reset),
        .s_valid (s_valid),
        .s_ready (s_ready),
        .s_data  (s_data),
        .r_valid (r_valid),
        .r_ready (r_ready),
        .r_data  (r_data),
        .coefs   (coefs),
        .idle    (idle),
        .dsp     (dsp0.seq)
    );

    dsp_mac u_mac (
        .clk   (clk),
        .reset (reset),
        .dsp   (dsp0.mac)
    );

    // Results with overflow flag
    stream_fifo #(.T(iir_result_t)) u_out_fifo (
        .clk        (clk),
        .reset      (reset),
        .push_valid (r_valid),
        .push_ready (r_ready),
        .push_data  (r_data),
        .pop_valid  (out_valid),
        .pop_ready  (out_ready),
        .pop_data   (out_res)
    );

    assign out_data = out_res.data;
    assign out_ovf  = out_res.ovf;

endmodule

// File: dv/iir_ref_model.svh
// Biquad reference model for the testbench
// Five-term sum at full 48-bit width, output taken from bits 33..16
// with wrap, overflow when bits 47..33 are not a sign extension

`ifndef IIR_REF_MODEL_SVH
`define IIR_REF_MODEL_SVH

coef_t   ref_coefs [`IIR_NUM_COEFS];
sample_t ref_x1;
sample_t ref_x2;
sample_t ref_y1;
sample_t ref_y2;

// Coefficients and history back to the reset state
function automatic void reset_model();
    for (int i = 0; i < `IIR_NUM_COEFS; i++) begin
        ref_coefs[i] = '0;
    end
    ref_x1 = '0;
    ref_x2 = '0;
    ref_y1 = '0;
    ref_y2 = '0;
endfunction

// Writes past the last tap are dropped
function automatic void load_model_coef(input coef_addr_t addr, input coef_t data);
    if (int'(addr) < `IIR_NUM_COEFS) begin
        ref_coefs[addr] = data;
    end
endfunction

// One output sample, history advances afterwards
function automatic iir_result_t step_model(input sample_t x);
    acc_t        acc;
    iir_result_t res;
    // Feedback coefficients arrive negated, so every term adds
    acc = acc_t'(ref_coefs[0]) * acc_t'(x)
        + acc_t'(ref_coefs[1]) * acc_t'(ref_x1)
        + acc_t'(ref_coefs[2]) * acc_t'(ref_x2)
        + acc_t'(ref_coefs[3]) * acc_t'(ref_y1)
        + acc_t'(ref_coefs[4]) * acc_t'(ref_y2);
    res.data = acc[33:16];
    res.ovf  = (acc[47:33] != {15{acc[33]}});
    ref_x2 = ref_x1;
    ref_x1 = x;
    ref_y2 = ref_y1;
    // History keeps the wrapped output
    ref_y1 = res.data;
    return res;
endfunction

`endif

// File: dv/tb_iir_filter.sv
// Biquad filter testbench
// Random streams with gaps and output stalls, coefficient reloads
// and overflow cases, scored against a reference model

`timescale 1ns/1ps

`include "iir_params.svh"

module tb_iir_filter;
    import iir_pkg::*;

    localparam int TIMEOUT = 4000;

    logic        clk;
    logic        reset;
    logic        in_valid;
    logic        in_ready;
    sample_t     in_data;
    logic        out_valid;
    logic        out_ready;
    sample_t     out_data;
    logic        out_ovf;
    logic        coef_valid;
    logic        coef_ready;
    coef_addr_t  coef_addr;
    coef_t       coef_data;

    iir_result_t exp_q [$];
    iir_result_t held;
    int          errors, checks, tests_run, tests_failed;
    int          stall_pct, ovf_seen, err_start;
    logic        sink_on, stalled, aborted;
    coef_addr_t  rnd_addr;
    coef_t       rnd_coef;

    `include "iir_ref_model.svh"

    iir_filter_top dut0 (
        .clk        (clk),
        .reset      (reset),
        .in_valid   (in_valid),
        .in_ready   (in_ready),
        .in_data    (in_data),
        .out_valid  (out_valid),
        .out_ready  (out_ready),
        .out_data   (out_data),
        .out_ovf    (out_ovf),
        .coef_valid (coef_valid),
        .coef_ready (coef_ready),
        .coef_addr  (coef_addr),
        .coef_data  (coef_data)
    );

    // 100 MHz
    always #5 clk = ~clk;

    // ------------------------------------------------------------
    // Scoring helpers
    // ------------------------------------------------------------
    task automatic compare_value(input string name, input int expected, input int actual);
        checks++;
        assert (actual == expected) else begin
            $display("FAIL t=%0t %s expected %0d got %0d", $time, name, expected, actual);
            errors++;
        end
    endtask

    task automatic note_timeout(input string what);
        $display("ERROR t=%0t timed out waiting for %s", $time, what);
        errors++;
        aborted = 1'b1;
    endtask

    task automatic take_output();
        iir_result_t want;
        if (exp_q.size() == 0) begin
            $display("ERROR t=%0t result appeared with no sample outstanding", $time);
            errors++;
            return;
        end
        want = exp_q.pop_front();
        compare_value("out_data", int'(want.data), int'(out_data));
        compare_value("out_ovf", int'(want.ovf), int'(out_ovf));
        if (out_ovf) begin
            ovf_seen++;
        end
    endtask

    // Output sink whose handshakes complete on the next rising edge
    always @(negedge clk) begin
        if (!reset && sink_on) begin
            if (stalled) begin
                compare_value("out_valid (stalled)", 1, int'(out_valid));
                compare_value("out_data (stalled)", int'(held.data), int'(out_data));
                compare_value("out_ovf (stalled)", int'(held.ovf), int'(out_ovf));
            end
            out_ready = ($urandom_range(0, 99) >= stall_pct);
            if (out_valid && out_ready) begin
                take_output();
            end
            stalled   = out_valid && !out_ready;
            held.data = out_data;
            held.ovf  = out_ovf;
        end
    end

    // ------------------------------------------------------------
    // Stimulus tasks start and end on a falling edge
    // ------------------------------------------------------------
    task automatic send_sample(input sample_t x);
        int waited;
        waited = 0;
        if (aborted) return;
        in_valid = 1'b1;
        in_data  = x;
        while (!in_ready && waited < TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        if (!in_ready) begin
            note_timeout("in_ready");
            in_valid = 1'b0;
            return;
        end
        exp_q.push_back(step_model(x));
        @(negedge clk);
        in_valid = 1'b0;
    endtask

    task automatic write_coef(input coef_addr_t addr, input coef_t data);
        int waited;
        waited = 0;
        if (aborted) return;
        coef_valid = 1'b1;
        coef_addr  = addr;
        coef_data  = data;
        while (!coef_ready && waited < TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        if (!coef_ready) begin
            note_timeout("coef_ready");
            coef_valid = 1'b0;
            return;
        end
        load_model_coef(addr, data);
        @(negedge clk);
        coef_valid = 1'b0;
    endtask

    task automatic wait_drain();
        int waited;
        waited = 0;
        while (exp_q.size() != 0 && waited < TIMEOUT && !aborted) begin
            @(negedge clk);
            waited++;
        end
        if (exp_q.size() != 0 && !aborted) begin
            note_timeout("outstanding results");
        end
    endtask

    task automatic stream_random(input int count, input int max_gap);
        for (int i = 0; i < count; i++) begin
            send_sample(sample_t'($urandom));
            repeat ($urandom_range(0, max_gap)) @(negedge clk);
        end
    endtask

    task automatic report_test(input string name);
        tests_run++;
        if (errors != err_start) begin
            tests_failed++;
            $display("test %0d %s: failed with %0d errors", tests_run, name, errors - err_start);
        end else if (aborted) begin
            $display("test %0d %s: not run", tests_run, name);
        end else begin
            $display("test %0d %s: passed", tests_run, name);
        end
    endtask

    // ------------------------------------------------------------
    // Test sequence
    // ------------------------------------------------------------
    initial begin
        void'($urandom(32'hf2be_b085));
        clk        = 1'b0;
        reset      = 1'b1;
        in_valid   = 1'b0;
        in_data    = '0;
        out_ready  = 1'b0;
        coef_valid = 1'b0;
        coef_addr  = '0;
        coef_data  = '0;
        errors     = 0;
        checks     = 0;
        tests_run  = 0;
        tests_failed = 0;
        stall_pct  = 0;
        ovf_seen   = 0;
        sink_on    = 1'b0;
        stalled    = 1'b0;
        aborted    = 1'b0;
        held       = '0;
        reset_model();
        repeat (8) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        // Zero coefficients give zero outputs
        err_start = errors;
        compare_value("in_ready", 1, int'(in_ready));
        compare_value("coef_ready", 1, int'(coef_ready));
        compare_value("out_valid", 0, int'(out_valid));
        sink_on = 1'b1;
        stream_random(8, 2);
        repeat (2) send_sample('0);
        wait_drain();
        report_test("reset_defaults");

        // Poles at radius 0.63 so the tail decays over the zeros
        err_start = errors;
        write_coef(3'd0, 18'sd65536);
        write_coef(3'd1, 18'sd32768);
        write_coef(3'd2, 18'sd16384);
        write_coef(3'd3, 18'sd49152);
        write_coef(3'd4, -18'sd26214);
        send_sample(18'sd40000);
        repeat (24) send_sample('0);
        wait_drain();
        report_test("impulse_response");

        err_start = errors;
        stream_random(200, 3);
        wait_drain();
        report_test("random_stream");

        err_start = errors;
        stall_pct = 60;
        stream_random(120, 0);
        wait_drain();
        stall_pct = 0;
        report_test("back_pressure");

        // History is kept across reloads
        err_start = errors;
        repeat (3) begin
            for (int a = 5; a < 8; a++) begin
                write_coef(coef_addr_t'(a), coef_t'($urandom));
            end
            repeat (12) begin
                rnd_addr = coef_addr_t'($urandom_range(0, 7));
                rnd_coef = coef_t'(int'($urandom_range(0, 65535)) - 32768);
                write_coef(rnd_addr, rnd_coef);
            end
            stall_pct = 20;
            stream_random(40, 2);
            wait_drain();
            stall_pct = 0;
        end
        report_test("coef_reload");

        err_start = errors;
        ovf_seen  = 0;
        write_coef(3'd0, 18'sd131071);
        write_coef(3'd1, 18'sd131071);
        write_coef(3'd2, coef_t'(-131072));
        write_coef(3'd3, 18'sd98304);
        write_coef(3'd4, coef_t'(-98304));
        repeat (30) begin
            send_sample(($urandom_range(0, 1) == 1) ? 18'sd131071 : sample_t'(-131072));
        end
        wait_drain();
        if (ovf_seen == 0 && !aborted) begin
            $display("ERROR t=%0t overflow test never raised out_ovf", $time);
            errors++;
        end
        report_test("overflow");

        $display("summary: %0d tests, %0d failed, %0d checks, %0d errors",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

// File: build.f
+incdir+rtl
+incdir+dv
rtl/iir_pkg.sv
rtl/dsp_if.sv
rtl/dsp_mac.sv
rtl/stream_fifo.sv
rtl/coef_bank.sv
rtl/iir_sequencer.sv
rtl/iir_filter_top.sv
dv/tb_iir_filter.sv

// File: run_sim.sh
#!/bin/sh
# Build the biquad testbench with Verilator and run it.
# Exit status is 0 only when the pass line appears in the output.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    -f build.f --top-module tb_iir_filter \
    || { echo "Verilator build failed"; exit 1; }

out=$(./obj_dir/Vtb_iir_filter)
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -q "^TESTS PASSED$" && exit 0 || exit 1
